// File: nn_macros.svh
// MLP sizing macros: sample width, layer sizes, parameter store map and sigmoid breakpoints
`ifndef NN_MACROS_SVH
`define NN_MACROS_SVH

// Fixed-point sample width in bits
`define NN_RES        8

// Network shape
`define NN_IN         4     // Network inputs
`define NN_HID        4     // Hidden neurons in layer 1
`define NN_OUT        2     // Output neurons in layer 2

// Parameter store: weights at 0..23, biases at 24..29
`define NN_ADDR_W     5
`define NN_NUM_WGT    24    // Layer 1 at 0..15 neuron-major, layer 2 at 16..23
`define NN_NUM_BIAS   6     // Layer 1 at 24..27, layer 2 at 28..29

// Sigmoid saturation points
`define NN_SIG_LO     (-32)
`define NN_SIG_HI     32

`endif

// File: fixed_point_pkg.sv
// Fixed-point package: numeric types shared by the neurons and the sigmoid
`default_nettype none
`include "nn_macros.svh"

package fixed_point_pkg;

    // Inputs, weights, biases and activations
    // all share one signed format
    typedef logic signed [`NN_RES-1:0] sample_t;

    // Full-precision product of two samples
    typedef logic signed [2*`NN_RES-1:0] product_t;

    // The accumulator grows with the fan-in
    // so each neuron sizes its own

endpackage

`default_nettype wire

// File: nn_struct_pkg.sv
// Interface structs package: parameter write port and network result port
`default_nettype none
`include "nn_macros.svh"

package nn_struct_pkg;

    // Parameter store address, covers weights and biases
    typedef logic [`NN_ADDR_W-1:0] wgt_addr_t;

    // Strobed write into the parameter store, no acknowledge
    typedef struct packed {
        logic                     wr;      // Write strobe, one cycle
        wgt_addr_t                addr;    // Addresses past the store are dropped
        fixed_point_pkg::sample_t data;
    } wgt_write_t;

    // Output of the second layer
    // class_out[0] sits in the low byte
    typedef struct packed {
        logic                                  valid;      // One cycle per sample
        fixed_point_pkg::sample_t [`NN_OUT-1:0] class_out;  // Sigmoid outputs 0..127
    } mlp_result_t;

endpackage

`default_nettype wire

// File: neuron.sv
// Neuron: signed dot product plus bias, sign-magnitude rescale and registered output
`default_nettype none
`timescale 1ns/1ps
`include "nn_macros.svh"

module neuron #(
    parameter int fan_in = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [fan_in*`NN_RES-1:0] in_data,     // Element 0 in the low byte
    input  logic [fan_in*`NN_RES-1:0] weight,      // Same packing as in_data
    input  fixed_point_pkg::sample_t  bias,        // Added unshifted
    output fixed_point_pkg::sample_t  neuron_out
);
    import fixed_point_pkg::*;

    localparam int idx_w = $clog2(fan_in);
    localparam int acc_w = 2*`NN_RES + idx_w;       // Room for fan_in full products
    localparam int shift = `NN_RES + idx_w + 1;     // Rescale back to sample range

    typedef logic signed [acc_w-1:0] acc_t;
    typedef logic signed [acc_w:0]   z_t;           // Guard bit for the bias add

    product_t       prod [fan_in];
    acc_t           acc;
    z_t             z;
    logic           z_neg;
    logic [acc_w:0] z_mag;                          // Magnitude of z, unsigned
    sample_t        mag_low;

    // Element-wise multiply and accumulate
    always_comb begin
        acc = '0;
        for (int i = 0; i < fan_in; i++) begin
            prod[i] = product_t'(sample_t'(in_data[i*`NN_RES +: `NN_RES]))
                    * product_t'(sample_t'(weight[i*`NN_RES +: `NN_RES]));
            acc = acc + acc_t'(prod[i]);           // Sign-extended into the sum
        end
    end

    assign z     = z_t'(acc) + z_t'(bias);
    assign z_neg = z[acc_w];
    assign z_mag = z_neg ? $unsigned(-z) : $unsigned(z);

    // Shift right and keep 8 bits
    // shift + NN_RES lands exactly on the top of z_mag
    assign mag_low = z_mag[shift +: `NN_RES];

    // Sign restored on the way into the register
    always_ff @(posedge clk) begin
        if (reset) begin
            neuron_out <= '0;
        end else begin
            neuron_out <= z_neg ? -mag_low : mag_low;
        end
    end

    // Output starts from zero once reset has been applied
    a_out_cleared: assert property (@(posedge clk) reset |=> neuron_out == '0)
        else $error("neuron_out not cleared by reset");

endmodule

`default_nettype wire

// File: sigmoid_pwl.sv
// Piecewise-linear sigmoid: maps a signed neuron output onto 0..127, registered
`default_nettype none
`timescale 1ns/1ps
`include "nn_macros.svh"

module sigmoid_pwl (
    input  logic                     clk,
    input  logic                     reset,
    input  fixed_point_pkg::sample_t x,
    output fixed_point_pkg::sample_t y
);
    import fixed_point_pkg::*;

    localparam sample_t sig_lo = sample_t'(`NN_SIG_LO);
    localparam sample_t sig_hi = sample_t'(`NN_SIG_HI);
    localparam sample_t y_max  = sample_t'(2**(`NN_RES-1) - 1);   // 127
    localparam sample_t y_mid  = sample_t'(2**(`NN_RES-2));       // 64, sigmoid(0)

    logic    below;
    logic    above;
    sample_t lin;

    // Breakpoint compares are signed
    assign below = (x <= sig_lo);
    assign above = (x >= sig_hi);

    // Middle segment, slope 2
    // Only used strictly inside the breakpoints so 2x never overflows
    assign lin = y_mid + (x <<< 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            y <= '0;
        end else if (below) begin
            y <= '0;                               // Low saturation
        end else if (above) begin
            y <= y_max;                            // High saturation
        end else begin
            y <= lin;
        end
    end

    // Activation stays in the unsigned half of the sample range
    a_y_nonneg: assert property (@(posedge clk) disable iff (reset) !y[`NN_RES-1])
        else $error("sigmoid output negative: %h", y);

endmodule

`default_nettype wire

// File: neural_layer.sv
// Fully connected layer: parallel neurons, each followed by a sigmoid, valid delayed to match
`default_nettype none
`timescale 1ns/1ps
`include "nn_macros.svh"

module neural_layer #(
    parameter int fan_in      = 4,
    parameter int num_neurons = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_valid,
    input  logic [fan_in*`NN_RES-1:0]             in_data,    // Shared by all neurons
    input  logic [num_neurons*fan_in*`NN_RES-1:0] weight,     // Neuron-major
    input  logic [num_neurons*`NN_RES-1:0]        bias,
    output logic                                  out_valid,
    output logic [num_neurons*`NN_RES-1:0]        out_data    // Neuron 0 in the low byte
);
    import fixed_point_pkg::*;

    localparam int w_slice = fan_in*`NN_RES;   // Weight bits per neuron

    sample_t    neuron_out [num_neurons];      // Pre-activation, registered in neuron
    logic [1:0] valid_pipe;                    // One stage each for neuron and sigmoid

    for (genvar n = 0; n < num_neurons; n++) begin : g_neuron
        neuron #(
            .fan_in     (fan_in)
        ) u_neuron (
            .clk        (clk),
            .reset      (reset),
            .in_data    (in_data),
            .weight     (weight[n*w_slice +: w_slice]),
            .bias       (bias[n*`NN_RES +: `NN_RES]),
            .neuron_out (neuron_out[n])
        );

        // Activation goes straight onto the output bus
        sigmoid_pwl u_sigmoid (
            .clk        (clk),
            .reset      (reset),
            .x          (neuron_out[n]),
            .y          (out_data[n*`NN_RES +: `NN_RES])
        );
    end

    // Valid follows the data through both register stages
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[0], in_valid};
        end
    end

    assign out_valid = valid_pipe[1];

    // Nothing can leave the layer in the two cycles after reset
    a_valid_quiet: assert property (@(posedge clk) reset |=> !out_valid ##1 !out_valid)
        else $error("layer out_valid high too soon after reset");

endmodule

`default_nettype wire

// File: weight_store.sv
// Parameter store: register file of all weights and biases, strobed write, flat read buses
`default_nettype none
`timescale 1ns/1ps
`include "nn_macros.svh"

module weight_store (
    input  logic                              clk,
    input  logic                              reset,
    input  nn_struct_pkg::wgt_write_t         wgt_wr,
    output logic [`NN_HID*`NN_IN*`NN_RES-1:0]  l1_weight,
    output logic [`NN_HID*`NN_RES-1:0]         l1_bias,
    output logic [`NN_OUT*`NN_HID*`NN_RES-1:0] l2_weight,
    output logic [`NN_OUT*`NN_RES-1:0]         l2_bias
);
    import fixed_point_pkg::*;
    import nn_struct_pkg::*;

    localparam int num_regs  = `NN_NUM_WGT + `NN_NUM_BIAS;   // 30 entries
    localparam int l1_w_cnt  = `NN_HID*`NN_IN;
    localparam int l2_w_cnt  = `NN_OUT*`NN_HID;
    localparam int l2_w_base = l1_w_cnt;                     // 16
    localparam int l1_b_base = `NN_NUM_WGT;                  // 24
    localparam int l2_b_base = `NN_NUM_WGT + `NN_HID;        // 28

    sample_t store [num_regs];
    logic    addr_ok;

    // Writes past the last entry are dropped
    assign addr_ok = (wgt_wr.addr < wgt_addr_t'(num_regs));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                store[i] <= '0;
            end
        end else if (wgt_wr.wr && addr_ok) begin
            store[wgt_wr.addr] <= wgt_wr.data;     // Seen by the neurons next cycle
        end
    end

    // Read side, straight from the registers
    always_comb begin
        for (int i = 0; i < l1_w_cnt; i++) begin
            l1_weight[i*`NN_RES +: `NN_RES] = store[i];
        end
        for (int i = 0; i < l2_w_cnt; i++) begin
            l2_weight[i*`NN_RES +: `NN_RES] = store[l2_w_base + i];
        end
        for (int i = 0; i < `NN_HID; i++) begin
            l1_bias[i*`NN_RES +: `NN_RES] = store[l1_b_base + i];
        end
        for (int i = 0; i < `NN_OUT; i++) begin
            l2_bias[i*`NN_RES +: `NN_RES] = store[l2_b_base + i];
        end
    end

    // An out-of-range write leaves every parameter as it was
    a_oob_ignored: assert property (@(posedge clk) disable iff (reset)
        (wgt_wr.wr && !addr_ok) |=> $stable({l1_weight, l1_bias, l2_weight, l2_bias}))
        else $error("write to address %0d changed the store", $past(wgt_wr.addr));

endmodule

`default_nettype wire

// File: mlp_top.sv
// MLP top: parameter store feeding a 4-4 hidden layer and a 4-2 output layer
`default_nettype none
`timescale 1ns/1ps
`include "nn_macros.svh"

module mlp_top (
    input  logic                       clk,
    input  logic                       reset,
    input  nn_struct_pkg::wgt_write_t  wgt_wr,     // Parameter load port
    input  logic                       in_valid,   // One cycle per sample
    input  logic [`NN_IN*`NN_RES-1:0]  in_data,    // Element 0 in the low byte
    output nn_struct_pkg::mlp_result_t result      // Valid 4 cycles after in_valid
);

    // Parameter buses
    logic [`NN_HID*`NN_IN*`NN_RES-1:0]  l1_weight;
    logic [`NN_HID*`NN_RES-1:0]         l1_bias;
    logic [`NN_OUT*`NN_HID*`NN_RES-1:0] l2_weight;
    logic [`NN_OUT*`NN_RES-1:0]         l2_bias;

    // Hidden activations, 2 cycles behind the input
    logic                               hid_valid;
    logic [`NN_HID*`NN_RES-1:0]         hid_data;

    // Output layer
    logic                               out_valid;
    logic [`NN_OUT*`NN_RES-1:0]         out_data;

    weight_store u_store (
        .clk       (clk),
        .reset     (reset),
        .wgt_wr    (wgt_wr),
        .l1_weight (l1_weight),
        .l1_bias   (l1_bias),
        .l2_weight (l2_weight),
        .l2_bias   (l2_bias)
    );

    neural_layer #(.fan_in(`NN_IN), .num_neurons(`NN_HID)) layer1 (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_data(in_data),
        .weight(l1_weight), .bias(l1_bias),
        .out_valid(hid_valid), .out_data(hid_data)
    );

    neural_layer #(.fan_in(`NN_HID), .num_neurons(`NN_OUT)) layer2 (
        .clk(clk), .reset(reset),
        .in_valid(hid_valid), .in_data(hid_data),
        .weight(l2_weight), .bias(l2_bias),
        .out_valid(out_valid), .out_data(out_data)
    );

    assign result = '{valid: out_valid, class_out: out_data};

endmodule

`default_nettype wire

// File: mlp_tb.sv
// MLP testbench that loads parameters, drives samples and checks results against a reference network
`default_nettype none
`timescale 1ns/1ps
`include "nn_macros.svh"

module mlp_tb;
    import fixed_point_pkg::*;
    import nn_struct_pkg::*;

    localparam int num_params    = `NN_NUM_WGT + `NN_NUM_BIAS;   // 30 store entries
    localparam int rescale_shift = `NN_RES + $clog2(`NN_IN) + 1;  // 11 for a fan-in of 4
    localparam int wait_limit    = 200;                           // Cycles before a wait gives up
    localparam int latency       = 4;                             // in_valid to result.valid
    localparam sample_t s_max    = sample_t'(127);
    localparam sample_t s_min    = sample_t'(-128);

    logic                        clk = 1'b0;
    logic                        reset;
    wgt_write_t                  wgt_wr;
    logic                        in_valid;
    logic [`NN_IN*`NN_RES-1:0]   in_data;
    mlp_result_t                 result;

    sample_t                     wgt_model [num_params];  // Own copy of the store contents
    logic [`NN_OUT*`NN_RES-1:0]  exp_q [$];               // Expected class_out in arrival order
    logic [`NN_OUT*`NN_RES-1:0]  last_out;                // Last class_out seen with valid
    int seed        = 32'h46d4;
    int mismatches  = 0;
    int failures    = 0;
    int checked     = 0;
    int run_len     = 0;                                  // Consecutive valid cycles
    int longest_run = 0;

    mlp_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .wgt_wr   (wgt_wr),
        .in_valid (in_valid),
        .in_data  (in_data),
        .result   (result)
    );

    always #5 clk = ~clk;   // 10 ns period

    // Dot product plus bias followed by the sign-magnitude rescale
    function automatic sample_t neuron_ref(input logic [`NN_IN*`NN_RES-1:0] x,
                                           input logic [`NN_IN*`NN_RES-1:0] w,
                                           input sample_t b);
        int z;
        int xi;
        int wi;
        int mag;
        z = int'(b);                                  // Bias enters unshifted
        for (int i = 0; i < `NN_IN; i++) begin
            xi = int'(sample_t'(x[i*`NN_RES +: `NN_RES]));
            wi = int'(sample_t'(w[i*`NN_RES +: `NN_RES]));
            z  = z + xi * wi;
        end
        mag = (z < 0) ? -z : z;
        mag = (mag >> rescale_shift) & 255;           // Keep low 8 bits
        return (z < 0) ? sample_t'(-mag) : sample_t'(mag);
    endfunction

    // Three-segment sigmoid onto 0..127
    function automatic sample_t sigmoid_ref(input sample_t x);
        if (int'(x) <= `NN_SIG_LO) begin
            return sample_t'(0);
        end
        if (int'(x) >= `NN_SIG_HI) begin
            return s_max;
        end
        return sample_t'(64 + 2*int'(x));
    endfunction

    // Whole network from the model copy of the weights
    function automatic logic [`NN_OUT*`NN_RES-1:0] network_ref(
        input logic [`NN_IN*`NN_RES-1:0] x);
        logic [`NN_HID*`NN_RES-1:0] hid;
        logic [`NN_OUT*`NN_RES-1:0] out;
        logic [`NN_IN*`NN_RES-1:0]  w;
        for (int n = 0; n < `NN_HID; n++) begin
            for (int i = 0; i < `NN_IN; i++) begin
                w[i*`NN_RES +: `NN_RES] = wgt_model[n*`NN_IN + i];   // Neuron-major
            end
            hid[n*`NN_RES +: `NN_RES] =
                sigmoid_ref(neuron_ref(x, w, wgt_model[`NN_NUM_WGT + n]));
        end
        for (int m = 0; m < `NN_OUT; m++) begin
            for (int i = 0; i < `NN_HID; i++) begin
                w[i*`NN_RES +: `NN_RES] = wgt_model[`NN_HID*`NN_IN + m*`NN_HID + i];
            end
            out[m*`NN_RES +: `NN_RES] =
                sigmoid_ref(neuron_ref(hid, w, wgt_model[`NN_NUM_WGT + `NN_HID + m]));
        end
        return out;
    endfunction

    function automatic sample_t rand_sample();
        return sample_t'($random(seed));
    endfunction

    function automatic logic [`NN_IN*`NN_RES-1:0] rand_input();
        logic [`NN_IN*`NN_RES-1:0] v;
        for (int i = 0; i < `NN_IN; i++) begin
            v[i*`NN_RES +: `NN_RES] = rand_sample();
        end
        return v;
    endfunction

    task automatic finish_run();
        $display("checked %0d results, %0d mismatches, %0d other errors",
                 checked, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // One-cycle write strobe issued on a falling edge
    task automatic write_param(input int addr, input sample_t data);
        wgt_wr.wr   = 1'b1;
        wgt_wr.addr = wgt_addr_t'(addr);
        wgt_wr.data = data;
        if (addr < num_params) begin
            wgt_model[addr] = data;                   // Store drops addresses past the end
        end
        @(negedge clk);
        wgt_wr.wr = 1'b0;
    endtask

    task automatic load_random();
        for (int a = 0; a < num_params; a++) begin
            write_param(a, rand_sample());
        end
    endtask

    task automatic load_uniform(input sample_t w1, input sample_t b1,
                                input sample_t w2, input sample_t b2);
        for (int a = 0; a < num_params; a++) begin
            if (a < `NN_HID*`NN_IN) begin
                write_param(a, w1);
            end else if (a < `NN_NUM_WGT) begin
                write_param(a, w2);
            end else if (a < `NN_NUM_WGT + `NN_HID) begin
                write_param(a, b1);
            end else begin
                write_param(a, b2);
            end
        end
    endtask

    task automatic send_sample(input logic [`NN_IN*`NN_RES-1:0] x);
        in_valid = 1'b1;
        in_data  = x;
        exp_q.push_back(network_ref(x));
        @(negedge clk);
        in_valid = 1'b0;                              // in_data is held and the neurons keep computing
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results still missing after %0d cycles",
                     exp_q.size(), cycles);
            failures++;
            finish_run();
        end else begin
            @(negedge clk);
        end
    endtask

    // Single sample that counts falling edges until result.valid
    task automatic send_and_time(input logic [`NN_IN*`NN_RES-1:0] x);
        int lat;
        send_sample(x);
        lat = 1;
        while (!result.valid && lat < wait_limit) begin
            @(negedge clk);
            lat++;
        end
        if (!result.valid) begin
            $display("timeout: result.valid never rose after a single sample");
            failures++;
            finish_run();
        end else begin
            if (lat != latency) begin
                $display("result.valid came %0d cycles after in_valid, expected %0d",
                         lat, latency);
                failures++;
            end
            wait_drained();
        end
    endtask

    // Compares every result against the queue
    always @(negedge clk) begin
        logic [`NN_OUT*`NN_RES-1:0] expected;
        if (!reset && result.valid) begin
            run_len++;
            if (run_len > longest_run) begin
                longest_run = run_len;
            end
            if (exp_q.size() == 0) begin
                $display("result.valid high with no sample pending");
                failures++;
            end else begin
                expected = exp_q.pop_front();
                for (int m = 0; m < `NN_OUT; m++) begin
                    if (result.class_out[m] !== expected[m*`NN_RES +: `NN_RES]) begin
                        $display("MISMATCH class_out[%0d]: got %h, expected %h",
                                 m, result.class_out[m], expected[m*`NN_RES +: `NN_RES]);
                        mismatches++;
                    end
                end
                checked++;
            end
            last_out = result.class_out;
        end else begin
            run_len = 0;
        end
    end

    initial begin
        logic [`NN_IN*`NN_RES-1:0]  saved_in;
        logic [`NN_OUT*`NN_RES-1:0] saved_out;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        wgt_wr   = '0;
        for (int a = 0; a < num_params; a++) begin
            wgt_model[a] = '0;                        // Store clears on reset
        end
        repeat (10) @(negedge clk);
        if (result.valid !== 1'b0 || result.class_out !== '0) begin
            $display("MISMATCH result under reset: got %h, expected %h", result, '0);
            mismatches++;
        end
        reset = 1'b0;

        // Quiet outputs and then zero weights so only the biases matter
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            if (result.valid !== 1'b0) begin
                $display("result.valid rose after reset with no sample sent");
                failures++;
            end
        end
        send_and_time(rand_input());
        if (last_out !== {`NN_OUT{8'd64}}) begin
            $display("MISMATCH class_out with zero store: got %h, expected %h",
                     last_out, {`NN_OUT{8'd64}});
            mismatches++;
        end
        for (int a = `NN_NUM_WGT; a < num_params; a++) begin
            write_param(a, rand_sample());
        end
        send_and_time(rand_input());

        // Every address written and then a single timed sample
        load_random();
        send_and_time(rand_input());

        // Extreme operands
        for (int c = 0; c < 8; c++) begin
            load_uniform(c[0] ? s_min : s_max, c[1] ? s_max : sample_t'(-127),
                         c[2] ? s_min : s_max, c[1] ? sample_t'(-127) : s_max);
            for (int i = 0; i < `NN_IN; i++) begin
                saved_in[i*`NN_RES +: `NN_RES] = (c[1] ^ (c[2] & i[0])) ? s_min : s_max;
            end
            send_sample(saved_in);
            wait_drained();
        end

        // Back-to-back burst with random weights
        load_random();
        longest_run = 0;
        for (int s = 0; s < 50; s++) begin
            send_sample(rand_input());
        end
        wait_drained();
        if (longest_run < 50) begin
            $display("burst results not back to back, longest run %0d of 50", longest_run);
            failures++;
        end

        // Out-of-range writes followed by a repeated sample
        saved_in = rand_input();
        send_sample(saved_in);
        wait_drained();
        saved_out = last_out;
        write_param(30, rand_sample());
        write_param(31, rand_sample());
        repeat (latency) @(negedge clk);              // in_data still holds saved_in
        if (result.class_out !== saved_out) begin
            $display("MISMATCH class_out after ignored write: got %h, expected %h",
                     result.class_out, saved_out);
            mismatches++;
        end
        send_sample(saved_in);
        wait_drained();
        if (last_out !== saved_out) begin
            $display("MISMATCH class_out on repeat: got %h, expected %h", last_out, saved_out);
            mismatches++;
        end

        // Fresh weight set between bursts
        load_random();
        longest_run = 0;
        for (int s = 0; s < 20; s++) begin
            send_sample(rand_input());
        end
        wait_drained();
        if (longest_run < 20) begin
            $display("second burst results not back to back, longest run %0d of 20",
                     longest_run);
            failures++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: mlp_top.f
+incdir+.
fixed_point_pkg.sv
nn_struct_pkg.sv
neuron.sv
sigmoid_pwl.sv
neural_layer.sv
weight_store.sv
mlp_top.sv
mlp_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = mlp_tb
FILELIST = mlp_top.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = sim failed
PASS_MSG = sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "TEST FAILED"; exit 1; \
	else \
		echo "TEST PASSED"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
